//--- epd_csr_pkg.sv
// Shared register map, field widths and operation record for the EPD control subsystem
package epd_csr_pkg;

    // CSR address map, one byte per register
    localparam logic [7:0] csr_addr_status      = 8'h00;
    localparam logic [7:0] csr_addr_enable      = 8'h01;
    localparam logic [7:0] csr_addr_lut_frame   = 8'h02;
    localparam logic [7:0] csr_addr_lut_addr_hi = 8'h03;
    localparam logic [7:0] csr_addr_lut_addr_lo = 8'h04;
    localparam logic [7:0] csr_addr_lut_wr      = 8'h05;
    localparam logic [7:0] csr_addr_op_left_hi  = 8'h06;
    localparam logic [7:0] csr_addr_op_left_lo  = 8'h07;
    localparam logic [7:0] csr_addr_op_right_hi = 8'h08;
    localparam logic [7:0] csr_addr_op_right_lo = 8'h09;
    localparam logic [7:0] csr_addr_op_top_hi   = 8'h0a;
    localparam logic [7:0] csr_addr_op_top_lo   = 8'h0b;
    localparam logic [7:0] csr_addr_op_bot_hi   = 8'h0c;
    localparam logic [7:0] csr_addr_op_bot_lo   = 8'h0d;
    localparam logic [7:0] csr_addr_op_param    = 8'h0e;
    localparam logic [7:0] csr_addr_op_length   = 8'h0f;
    localparam logic [7:0] csr_addr_op_cmd      = 8'h10;
    localparam logic [7:0] csr_addr_h_active_hi = 8'h11;
    localparam logic [7:0] csr_addr_h_active_lo = 8'h12;
    localparam logic [7:0] csr_addr_v_active_hi = 8'h13;
    localparam logic [7:0] csr_addr_v_active_lo = 8'h14;

    // Field widths
    localparam int coord_w     = 12;
    localparam int lut_addr_w  = 12;
    localparam int lut_frame_w = 6;

    // Frame count must agree with the default waveform table
    localparam logic [lut_frame_w-1:0] lut_frame_reset = 6'd38;

    localparam int op_fifo_depth = 4;

    // Status byte layout
    localparam int status_bit_enable   = 0;
    localparam int status_bit_queue    = 3;
    localparam int status_bit_held     = 4;
    localparam int status_bit_ready    = 5;
    localparam int status_bit_overflow = 6;

    typedef struct packed {
        logic [7:0]         cmd;
        logic [7:0]         param;
        logic [7:0]         length;
        logic [coord_w-1:0] left;
        logic [coord_w-1:0] right;
        logic [coord_w-1:0] top;
        logic [coord_w-1:0] bottom;
    } op_rec_t;

endpackage

//--- spi_byte_link.sv
// SPI mode 3 slave that turns address/data bytes into one-cycle register read/write requests
`timescale 1ns/1ps

module spi_byte_link (
    input  logic       clk,
    input  logic       rst,
    input  logic       spi_cs,
    input  logic       spi_sck,
    input  logic       spi_mosi,
    output logic       spi_miso,
    input  logic [7:0] req_rdata,
    input  logic       addr_hold,
    output logic [7:0] req_addr,
    output logic [7:0] req_wdata,
    output logic       req_ren,
    output logic       req_wen
);

    logic       last_sck;
    logic       data_phase;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic [7:0] rx_byte;
    logic       sck_rise;
    logic       sck_fall;
    logic       byte_done;

    // SCK idles high, mosi sampled on rise, miso driven on fall
    assign sck_rise  = !spi_cs && !last_sck && spi_sck;
    assign sck_fall  = !spi_cs && last_sck && !spi_sck;
    assign rx_byte   = {rx_shift, spi_mosi};
    assign byte_done = sck_rise && (bit_cnt == 3'd7);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_sck   <= 1'b1;
            data_phase <= 1'b0;
            bit_cnt    <= 3'd0;
            req_ren    <= 1'b0;
            req_wen    <= 1'b0;
            spi_miso   <= 1'b1;
            tx_shift   <= 8'hff;
        end else begin
            last_sck <= spi_sck;
            // First byte of a transaction is the address, the rest are data
            req_ren  <= byte_done && !data_phase;
            req_wen  <= byte_done && data_phase;
            if (spi_cs) begin
                data_phase <= 1'b0;
                bit_cnt    <= 3'd0;
                spi_miso   <= 1'b1;
                tx_shift   <= 8'hff;
            end else begin
                if (sck_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        data_phase <= 1'b1;
                    end
                end
                // Zeros shift in behind the read byte, so later bytes read 0x00
                if (req_ren) begin
                    tx_shift <= req_rdata;
                end else if (sck_fall) begin
                    spi_miso <= tx_shift[7];
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            rx_shift <= rx_byte[6:0];
        end
        if (byte_done && !data_phase) begin
            req_addr <= rx_byte;
        end else if (req_wen && !addr_hold) begin
            req_addr <= req_addr + 8'd1;
        end
        if (byte_done && data_phase) begin
            req_wdata <= rx_byte;
        end
    end

    a_req_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(req_ren && req_wen));

endmodule

//--- csr_regfile.sv
// Register file that executes SPI requests and feeds the LUT port and the operation queue
`timescale 1ns/1ps

module csr_regfile (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [7:0]                         req_addr,
    input  logic [7:0]                         req_wdata,
    input  logic                               req_ren,
    input  logic                               req_wen,
    output logic [7:0]                         req_rdata,
    output logic                               addr_hold,
    input  logic                               sys_ready,
    input  logic                               fifo_not_empty,
    input  logic                               fifo_held,
    input  logic                               fifo_overflow,
    output logic                               enable,
    output logic [epd_csr_pkg::lut_frame_w-1:0] lut_frame,
    output logic [epd_csr_pkg::coord_w-1:0]    h_active,
    output logic [epd_csr_pkg::coord_w-1:0]    v_active,
    output logic                               lut_we,
    output logic [epd_csr_pkg::lut_addr_w-1:0] lut_wr_addr,
    output logic [7:0]                         lut_wr_data,
    output logic                               op_push,
    output epd_csr_pkg::op_rec_t               op_rec
);
    import epd_csr_pkg::*;

    logic [lut_addr_w-1:0] lut_addr;
    logic [7:0]            rec_cmd;
    logic [7:0]            rec_param;
    logic [7:0]            rec_length;
    logic [coord_w-1:0]    rec_left;
    logic [coord_w-1:0]    rec_right;
    logic [coord_w-1:0]    rec_top;
    logic [coord_w-1:0]    rec_bottom;
    logic [7:0]            status;
    logic [7:0]            rd_mux;

    // Data ports take repeated writes at one address
    assign addr_hold = (req_addr == csr_addr_lut_wr) || (req_addr == csr_addr_op_cmd);

    assign lut_wr_addr = lut_addr;
    assign op_rec = '{rec_cmd, rec_param, rec_length, rec_left, rec_right, rec_top, rec_bottom};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable    <= 1'b0;
            lut_frame <= lut_frame_reset;
            lut_addr  <= '0;
            lut_we    <= 1'b0;
            op_push   <= 1'b0;
        end else begin
            lut_we  <= req_wen && (req_addr == csr_addr_lut_wr);
            op_push <= req_wen && (req_addr == csr_addr_op_cmd);
            // Step past the entry just written
            if (lut_we) begin
                lut_addr <= lut_addr + 1'b1;
            end
            if (req_wen) begin
                case (req_addr)
                    csr_addr_enable:      enable <= req_wdata[0];
                    csr_addr_lut_frame:   lut_frame <= req_wdata[lut_frame_w-1:0];
                    csr_addr_lut_addr_hi: lut_addr[lut_addr_w-1:8] <= req_wdata[lut_addr_w-9:0];
                    csr_addr_lut_addr_lo: lut_addr[7:0] <= req_wdata;
                    default: ;
                endcase
            end
        end
    end

    // Operation fields and timing values
    always_ff @(posedge clk) begin
        if (req_wen) begin
            case (req_addr)
                csr_addr_lut_wr:      lut_wr_data <= req_wdata;
                csr_addr_op_left_hi:  rec_left[coord_w-1:8] <= req_wdata[coord_w-9:0];
                csr_addr_op_left_lo:  rec_left[7:0] <= req_wdata;
                csr_addr_op_right_hi: rec_right[coord_w-1:8] <= req_wdata[coord_w-9:0];
                csr_addr_op_right_lo: rec_right[7:0] <= req_wdata;
                csr_addr_op_top_hi:   rec_top[coord_w-1:8] <= req_wdata[coord_w-9:0];
                csr_addr_op_top_lo:   rec_top[7:0] <= req_wdata;
                csr_addr_op_bot_hi:   rec_bottom[coord_w-1:8] <= req_wdata[coord_w-9:0];
                csr_addr_op_bot_lo:   rec_bottom[7:0] <= req_wdata;
                csr_addr_op_param:    rec_param <= req_wdata;
                csr_addr_op_length:   rec_length <= req_wdata;
                csr_addr_op_cmd:      rec_cmd <= req_wdata;
                csr_addr_h_active_hi: h_active[coord_w-1:8] <= req_wdata[coord_w-9:0];
                csr_addr_h_active_lo: h_active[7:0] <= req_wdata;
                csr_addr_v_active_hi: v_active[coord_w-1:8] <= req_wdata[coord_w-9:0];
                csr_addr_v_active_lo: v_active[7:0] <= req_wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        status = 8'h00;
        status[status_bit_enable]   = enable;
        status[status_bit_queue]    = fifo_not_empty;
        status[status_bit_held]     = fifo_held;
        status[status_bit_ready]    = sys_ready;
        status[status_bit_overflow] = fifo_overflow;
    end

    always_comb begin
        case (req_addr)
            csr_addr_status:      rd_mux = status;
            csr_addr_enable:      rd_mux = 8'(enable);
            csr_addr_lut_frame:   rd_mux = 8'(lut_frame);
            csr_addr_lut_addr_hi: rd_mux = 8'(lut_addr[lut_addr_w-1:8]);
            csr_addr_lut_addr_lo: rd_mux = lut_addr[7:0];
            csr_addr_lut_wr:      rd_mux = lut_wr_data;
            csr_addr_op_left_hi:  rd_mux = 8'(rec_left[coord_w-1:8]);
            csr_addr_op_left_lo:  rd_mux = rec_left[7:0];
            csr_addr_op_right_hi: rd_mux = 8'(rec_right[coord_w-1:8]);
            csr_addr_op_right_lo: rd_mux = rec_right[7:0];
            csr_addr_op_top_hi:   rd_mux = 8'(rec_top[coord_w-1:8]);
            csr_addr_op_top_lo:   rd_mux = rec_top[7:0];
            csr_addr_op_bot_hi:   rd_mux = 8'(rec_bottom[coord_w-1:8]);
            csr_addr_op_bot_lo:   rd_mux = rec_bottom[7:0];
            csr_addr_op_param:    rd_mux = rec_param;
            csr_addr_op_length:   rd_mux = rec_length;
            csr_addr_op_cmd:      rd_mux = rec_cmd;
            csr_addr_h_active_hi: rd_mux = 8'(h_active[coord_w-1:8]);
            csr_addr_h_active_lo: rd_mux = h_active[7:0];
            csr_addr_v_active_hi: rd_mux = 8'(v_active[coord_w-1:8]);
            csr_addr_v_active_lo: rd_mux = v_active[7:0];
            default:              rd_mux = 8'h00;
        endcase
    end

    // Read bus carries data only while the link strobes a read
    assign req_rdata = req_ren ? rd_mux : 8'h00;

    a_port_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(lut_we && op_push));

endmodule

//--- lut_ram.sv
// Waveform lookup memory, written from the CSR port and read by the display engine
`timescale 1ns/1ps

module lut_ram (
    input  logic                               clk,
    input  logic                               we,
    input  logic [epd_csr_pkg::lut_addr_w-1:0] wr_addr,
    input  logic [7:0]                         wr_data,
    input  logic [epd_csr_pkg::lut_addr_w-1:0] rd_addr,
    output logic [7:0]                         rd_data
);
    import epd_csr_pkg::*;

    logic [7:0] mem [2**lut_addr_w];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle of read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- op_fifo.sv
// First-word fall-through queue with valid/ready output and sticky overflow flag
`timescale 1ns/1ps

module op_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,
    output logic     not_empty,
    output logic     held,
    output logic     overflow
);
    import epd_csr_pkg::*;

    localparam int ptr_w = $clog2(op_fifo_depth);

    payload_t                       mem [op_fifo_depth];
    logic [ptr_w-1:0]               head;
    logic [ptr_w-1:0]               tail;
    logic [$clog2(op_fifo_depth+1)-1:0] count;
    logic                           full;
    logic                           do_push;
    logic                           do_pop;

    assign full      = (count == op_fifo_depth);
    assign do_push   = push && !full;
    assign do_pop    = out_valid && out_ready;
    assign out_valid = (count != 0);
    assign out_data  = mem[head];
    assign not_empty = out_valid;
    assign held      = out_valid && !out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) tail <= tail + 1'b1;
            if (do_pop) head <= head + 1'b1;
            count <= count + do_push - do_pop;
            // A dropped record is remembered until reset
            if (push && full) overflow <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail] <= push_data;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- epd_ctrl_top.sv
// EPD control subsystem top, SPI configuration link to register file, waveform LUT and op queue
`timescale 1ns/1ps

module epd_ctrl_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                spi_cs,
    input  logic                                spi_sck,
    input  logic                                spi_mosi,
    output logic                                spi_miso,
    input  logic                                sys_ready,
    output logic                                enable,
    output logic [epd_csr_pkg::lut_frame_w-1:0] lut_frame,
    output logic [epd_csr_pkg::coord_w-1:0]     h_active,
    output logic [epd_csr_pkg::coord_w-1:0]     v_active,
    input  logic [epd_csr_pkg::lut_addr_w-1:0]  lut_rd_addr,
    output logic [7:0]                          lut_rd_data,
    output logic                                op_valid,
    input  logic                                op_ready,
    output logic [7:0]                          op_cmd,
    output logic [7:0]                          op_param,
    output logic [7:0]                          op_length,
    output logic [epd_csr_pkg::coord_w-1:0]     op_left,
    output logic [epd_csr_pkg::coord_w-1:0]     op_right,
    output logic [epd_csr_pkg::coord_w-1:0]     op_top,
    output logic [epd_csr_pkg::coord_w-1:0]     op_bottom
);
    import epd_csr_pkg::*;

    logic [7:0]            req_addr;
    logic [7:0]            req_wdata;
    logic [7:0]            req_rdata;
    logic                  req_ren;
    logic                  req_wen;
    logic                  addr_hold;
    logic                  lut_we;
    logic [lut_addr_w-1:0] lut_wr_addr;
    logic [7:0]            lut_wr_data;
    logic                  op_push;
    op_rec_t               op_in;
    op_rec_t               op_out;
    logic                  fifo_not_empty;
    logic                  fifo_held;
    logic                  fifo_overflow;

    spi_byte_link u_link (
        .clk       (clk),
        .rst       (rst),
        .spi_cs    (spi_cs),
        .spi_sck   (spi_sck),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .req_rdata (req_rdata),
        .addr_hold (addr_hold),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ren   (req_ren),
        .req_wen   (req_wen)
    );

    csr_regfile u_regs (
        .clk            (clk),
        .rst            (rst),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_ren        (req_ren),
        .req_wen        (req_wen),
        .req_rdata      (req_rdata),
        .addr_hold      (addr_hold),
        .sys_ready      (sys_ready),
        .fifo_not_empty (fifo_not_empty),
        .fifo_held      (fifo_held),
        .fifo_overflow  (fifo_overflow),
        .enable         (enable),
        .lut_frame      (lut_frame),
        .h_active       (h_active),
        .v_active       (v_active),
        .lut_we         (lut_we),
        .lut_wr_addr    (lut_wr_addr),
        .lut_wr_data    (lut_wr_data),
        .op_push        (op_push),
        .op_rec         (op_in)
    );

    lut_ram u_lut (
        .clk     (clk),
        .we      (lut_we),
        .wr_addr (lut_wr_addr),
        .wr_data (lut_wr_data),
        .rd_addr (lut_rd_addr),
        .rd_data (lut_rd_data)
    );

    op_fifo #(
        .payload_t (op_rec_t)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (op_push),
        .push_data (op_in),
        .out_valid (op_valid),
        .out_data  (op_out),
        .out_ready (op_ready),
        .not_empty (fifo_not_empty),
        .held      (fifo_held),
        .overflow  (fifo_overflow)
    );

    // Engine side sees the record as separate fields
    assign op_cmd    = op_out.cmd;
    assign op_param  = op_out.param;
    assign op_length = op_out.length;
    assign op_left   = op_out.left;
    assign op_right  = op_out.right;
    assign op_top    = op_out.top;
    assign op_bottom = op_out.bottom;

endmodule

//--- tb_spi_tasks.svh
// SPI host, random byte source, value check and register access tasks, included in the testbench
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// Leaves the caller 2 ns after a rising edge, where inputs change
task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
endtask

function automatic logic [7:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
endfunction

task automatic expect_equal(input logic [31:0] got, input logic [31:0] expected,
                            input string what);
    if (got !== expected) begin
        $display("** Error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, expected);
        $display("tests failed");
        $fatal(1, "value mismatch");
    end
endtask

task automatic begin_frame();
    spi_cs = 1'b0;
    wait_cycles(sck_half);
endtask

task automatic end_frame();
    spi_cs = 1'b1;
    wait_cycles(2 * sck_half);
endtask

// Mode 3, SCK idles high and the slave samples on the rise
task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
        spi_sck  = 1'b0;
        spi_mosi = b[i];
        wait_cycles(sck_half);
        spi_sck = 1'b1;
        wait_cycles(sck_half);
    end
endtask

task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    begin_frame();
    send_byte(addr);
    send_byte(data);
    end_frame();
endtask

task automatic read_reg(input logic [7:0] addr, output logic [7:0] value);
    begin_frame();
    send_byte(addr);
    spi_mosi = 1'b0;
    for (int i = 7; i >= 0; i--) begin
        spi_sck = 1'b0;
        wait_cycles(sck_half);
        value[i] = spi_miso;
        // No eighth rise, so the dummy byte never becomes a write
        if (i > 0) begin
            spi_sck = 1'b1;
            wait_cycles(sck_half);
        end
    end
    spi_cs = 1'b1;
    wait_cycles(1);
    spi_sck = 1'b1;
    wait_cycles(2 * sck_half);
endtask

`endif

//--- tb_epd_ctrl.sv
// Testbench for the EPD control subsystem that drives the SPI link and checks registers, LUT and queue
`timescale 1ns/1ps

module tb_epd_ctrl;
    import epd_csr_pkg::*;

    localparam int sck_half        = 4;
    localparam int byte_cycles     = 16 * sck_half + 16;
    localparam int tbl_len         = 20;
    localparam int fixed_bytes     = 120;
    localparam int watchdog_cycles = (tbl_len * 4 + fixed_bytes) * byte_cycles + 1000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   spi_cs;
    logic                   spi_sck;
    logic                   spi_mosi;
    logic                   spi_miso;
    logic                   sys_ready;
    logic                   enable;
    logic [lut_frame_w-1:0] lut_frame;
    logic [coord_w-1:0]     h_active;
    logic [coord_w-1:0]     v_active;
    logic [lut_addr_w-1:0]  lut_rd_addr;
    logic [7:0]             lut_rd_data;
    logic                   op_valid;
    logic                   op_ready;
    logic [7:0]             op_cmd;
    logic [7:0]             op_param;
    logic [7:0]             op_length;
    logic [coord_w-1:0]     op_left;
    logic [coord_w-1:0]     op_right;
    logic [coord_w-1:0]     op_top;
    logic [coord_w-1:0]     op_bottom;

    logic [31:0]           lcg_state;
    logic [7:0]            rd;
    logic [7:0]            lut_bytes [8];
    logic [lut_addr_w-1:0] lut_base;
    logic [lut_addr_w-1:0] lut_end;
    logic [7:0]            timing_vals [4] = '{8'ha3, 8'h20, 8'hf2, 8'h58};
    logic [7:0]            exp_cmd [6];
    logic [7:0]            exp_param [6];
    logic [7:0]            exp_length [6];
    logic [coord_w-1:0]    exp_left [6];
    logic [coord_w-1:0]    exp_right [6];
    logic [coord_w-1:0]    exp_top [6];
    logic [coord_w-1:0]    exp_bottom [6];

    // Registers under test and the bits each one keeps
    // Data ports and status are left out
    logic [7:0] tbl_addr [tbl_len] = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h06, 8'h07, 8'h08,
                                       8'h09, 8'h0a, 8'h0b, 8'h0c, 8'h0d, 8'h0e, 8'h0f,
                                       8'h11, 8'h12, 8'h13, 8'h14, 8'h15, 8'h7f};
    logic [7:0] tbl_mask [tbl_len] = '{8'h01, 8'h3f, 8'h0f, 8'hff, 8'h0f, 8'hff, 8'h0f,
                                       8'hff, 8'h0f, 8'hff, 8'h0f, 8'hff, 8'hff, 8'hff,
                                       8'h0f, 8'hff, 8'h0f, 8'hff, 8'h00, 8'h00};
    logic [7:0] tbl_wdata [tbl_len];
    logic [7:0] tbl_expect [tbl_len];

    epd_ctrl_top uut (
        .clk         (clk),
        .rst         (rst),
        .spi_cs      (spi_cs),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .sys_ready   (sys_ready),
        .enable      (enable),
        .lut_frame   (lut_frame),
        .h_active    (h_active),
        .v_active    (v_active),
        .lut_rd_addr (lut_rd_addr),
        .lut_rd_data (lut_rd_data),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op_cmd      (op_cmd),
        .op_param    (op_param),
        .op_length   (op_length),
        .op_left     (op_left),
        .op_right    (op_right),
        .op_top      (op_top),
        .op_bottom   (op_bottom)
    );

    always #20 clk = ~clk;

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the test sequence did not finish within %0d cycles", watchdog_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    `include "tb_spi_tasks.svh"

    // One burst from the left coordinate up to the command port
    task automatic issue_op(input int k);
        exp_left[k]   = {4'(next_random()), next_random()};
        exp_right[k]  = {4'(next_random()), next_random()};
        exp_top[k]    = {4'(next_random()), next_random()};
        exp_bottom[k] = {4'(next_random()), next_random()};
        exp_param[k]  = 8'h40 + 8'(k);
        exp_length[k] = next_random();
        exp_cmd[k]    = 8'hc0 + 8'(k);
        begin_frame();
        send_byte(csr_addr_op_left_hi);
        send_byte({4'ha, exp_left[k][11:8]});
        send_byte(exp_left[k][7:0]);
        send_byte({4'h5, exp_right[k][11:8]});
        send_byte(exp_right[k][7:0]);
        send_byte({4'hc, exp_top[k][11:8]});
        send_byte(exp_top[k][7:0]);
        send_byte({4'h3, exp_bottom[k][11:8]});
        send_byte(exp_bottom[k][7:0]);
        send_byte(exp_param[k]);
        send_byte(exp_length[k]);
        send_byte(exp_cmd[k]);
        end_frame();
    endtask

    task automatic drain_and_compare(input int count);
        op_ready = 1'b1;
        for (int j = 0; j < count; j++) begin
            expect_equal(op_valid, 1'b1, "op_valid while draining");
            expect_equal(op_cmd, exp_cmd[j], "op_cmd");
            expect_equal(op_param, exp_param[j], "op_param");
            expect_equal(op_length, exp_length[j], "op_length");
            expect_equal(op_left, exp_left[j], "op_left");
            expect_equal(op_right, exp_right[j], "op_right");
            expect_equal(op_top, exp_top[j], "op_top");
            expect_equal(op_bottom, exp_bottom[j], "op_bottom");
            wait_cycles(1);
        end
        op_ready = 1'b0;
        expect_equal(op_valid, 1'b0, "op_valid after draining");
    endtask

    initial begin
        lcg_state   = 32'h2b7d;
        rst         = 1'b1;
        spi_cs      = 1'b1;
        spi_sck     = 1'b1;
        spi_mosi    = 1'b0;
        sys_ready   = 1'b1;
        op_ready    = 1'b0;
        lut_rd_addr = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        wait_cycles(2);

        // Status holds only the ready bit after reset
        read_reg(csr_addr_status, rd);
        expect_equal(rd, 8'h20, "status after reset");
        expect_equal(op_valid, 1'b0, "op_valid after reset");
        expect_equal(enable, 1'b0, "enable after reset");
        read_reg(csr_addr_lut_frame, rd);
        expect_equal(rd, 8'd38, "lut frame after reset");
        expect_equal(lut_frame, 6'd38, "lut_frame port after reset");

        // Timing registers in one auto-incrementing burst
        begin_frame();
        send_byte(csr_addr_h_active_hi);
        for (int i = 0; i < 4; i++) begin
            send_byte(timing_vals[i]);
        end
        end_frame();
        for (int i = 0; i < 4; i++) begin
            read_reg(8'(csr_addr_h_active_hi + i), rd);
            expect_equal(rd, (i % 2 == 0) ? (timing_vals[i] & 8'h0f) : timing_vals[i],
                         "timing register readback");
        end
        expect_equal(h_active, {timing_vals[0][3:0], timing_vals[1]}, "h_active port");
        expect_equal(v_active, {timing_vals[2][3:0], timing_vals[3]}, "v_active port");

        // LUT data port with a base that crosses a 256 byte boundary
        lut_base = 12'h0fc;
        lut_end  = lut_base + 12'd8;
        begin_frame();
        send_byte(csr_addr_lut_addr_hi);
        send_byte({4'h0, lut_base[11:8]});
        send_byte(lut_base[7:0]);
        end_frame();
        begin_frame();
        send_byte(csr_addr_lut_wr);
        for (int i = 0; i < 8; i++) begin
            lut_bytes[i] = next_random();
            send_byte(lut_bytes[i]);
        end
        end_frame();
        read_reg(csr_addr_lut_addr_hi, rd);
        expect_equal(rd, {4'h0, lut_end[11:8]}, "lut address high after burst");
        read_reg(csr_addr_lut_addr_lo, rd);
        expect_equal(rd, lut_end[7:0], "lut address low after burst");
        read_reg(csr_addr_lut_wr, rd);
        expect_equal(rd, lut_bytes[7], "lut data port readback");
        for (int i = 0; i < 8; i++) begin
            lut_rd_addr = lut_base + 12'(i);
            wait_cycles(1);
            expect_equal(lut_rd_data, lut_bytes[i], "lut memory contents");
        end

        // Three operations queue up behind a stalled engine
        for (int k = 0; k < 3; k++) begin
            issue_op(k);
        end
        expect_equal(op_valid, 1'b1, "op_valid with queued records");
        read_reg(csr_addr_status, rd);
        expect_equal(rd, 8'h38, "status with held operation");
        drain_and_compare(3);

        // Six commands into a four entry queue while the other fields keep their values
        for (int j = 0; j < 6; j++) begin
            exp_cmd[j]    = 8'h80 + 8'(j);
            exp_param[j]  = exp_param[2];
            exp_length[j] = exp_length[2];
            exp_left[j]   = exp_left[2];
            exp_right[j]  = exp_right[2];
            exp_top[j]    = exp_top[2];
            exp_bottom[j] = exp_bottom[2];
        end
        begin_frame();
        send_byte(csr_addr_op_cmd);
        for (int j = 0; j < 6; j++) begin
            send_byte(exp_cmd[j]);
        end
        end_frame();
        read_reg(csr_addr_status, rd);
        expect_equal(rd, 8'h78, "status after overflow");
        drain_and_compare(4);
        read_reg(csr_addr_status, rd);
        expect_equal(rd, 8'h60, "status after overflow drain");

        // Ready bit follows the sys_ready input
        sys_ready = 1'b0;
        read_reg(csr_addr_status, rd);
        expect_equal(rd, 8'h40, "status with sys_ready low");
        sys_ready = 1'b1;

        write_reg(csr_addr_enable, 8'h01);
        expect_equal(enable, 1'b1, "enable port set");
        read_reg(csr_addr_status, rd);
        expect_equal(rd, 8'h61, "status with enable set");
        write_reg(csr_addr_enable, 8'h00);
        read_reg(csr_addr_status, rd);
        expect_equal(rd, 8'h60, "status with enable cleared");

        // Table of registers with random data
        for (int i = 0; i < tbl_len; i++) begin
            tbl_wdata[i]  = next_random();
            tbl_expect[i] = tbl_wdata[i] & tbl_mask[i];
        end
        for (int i = 0; i < tbl_len; i++) begin
            write_reg(tbl_addr[i], tbl_wdata[i]);
            read_reg(tbl_addr[i], rd);
            expect_equal(rd, tbl_expect[i], $sformatf("table readback at 0x%02h", tbl_addr[i]));
            if (tbl_addr[i] == csr_addr_lut_frame) begin
                expect_equal(lut_frame, tbl_expect[i], "lut_frame port");
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
epd_csr_pkg.sv
spi_byte_link.sv
csr_regfile.sv
lut_ram.sv
op_fifo.sv
epd_ctrl_top.sv
tb_epd_ctrl.sv
